//--- dzcpu_cfg.svh
`ifndef DZCPU_CFG_SVH
`define DZCPU_CFG_SVH

// Datapath widths
`define DZCPU_DATA_W 8
`define DZCPU_ADDR_W 16

`define DZCPU_QUEUE_DEPTH 4   // Fetched instruction entries

// Register values after reset
`define DZCPU_FLAGS_RESET 8'hB0
`define DZCPU_SP_RESET 16'hFFFE
`define DZCPU_PC_RESET 16'h0000

// Bit positions inside F
`define DZCPU_FLAG_Z 7
`define DZCPU_FLAG_N 6
`define DZCPU_FLAG_H 5
`define DZCPU_FLAG_C 4

`endif

//--- dzcpu_pkg.sv
`include "dzcpu_cfg.svh"

package dzcpu_pkg;

  // Register field of the opcode with M as the (HL) slot
  typedef enum logic [2:0] {
    REG_B = 3'd0,
    REG_C = 3'd1,
    REG_D = 3'd2,
    REG_E = 3'd3,
    REG_H = 3'd4,
    REG_L = 3'd5,
    REG_M = 3'd6,
    REG_A = 3'd7
  } regIdxE;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_ADC,
    ALU_SUB,
    ALU_AND,
    ALU_XOR,
    ALU_OR,
    ALU_INC,
    ALU_DEC
  } aluOpE;

  typedef enum logic {
    FETCH_OPCODE,
    FETCH_IMM     // Opcode held while its operand byte is read
  } fetchStateE;

  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_PUSH_HIGH,
    EXEC_PUSH_LOW
  } execStateE;

  typedef struct packed {
    logic [`DZCPU_DATA_W-1:0] opcode;
    logic [`DZCPU_DATA_W-1:0] imm;
    logic                     hasImm;
  } queueItemT;

endpackage

//--- dzcpuAlu.sv
`include "dzcpu_cfg.svh"

module dzcpuAlu
(
  input  dzcpu_pkg::aluOpE         op,
  input  logic [`DZCPU_DATA_W-1:0] operandA,
  input  logic [`DZCPU_DATA_W-1:0] operandB,
  input  logic [`DZCPU_DATA_W-1:0] flags,
  output logic [`DZCPU_DATA_W-1:0] result,
  output logic [`DZCPU_DATA_W-1:0] newFlags
);

  logic [`DZCPU_DATA_W:0] wide;     // Top bit is carry or borrow out of bit 7
  logic [4:0]             nibble;   // Bit 4 is carry or borrow out of bit 3
  logic                   carryIn;

  assign carryIn = (op == dzcpu_pkg::ALU_ADC) ? flags[`DZCPU_FLAG_C] : 1'b0;
  assign result  = wide[`DZCPU_DATA_W-1:0];

  always_comb
  begin
    wide     = '0;
    nibble   = '0;
    newFlags = '0;
    newFlags[`DZCPU_FLAG_C] = flags[`DZCPU_FLAG_C];
    case (op)
      dzcpu_pkg::ALU_ADD, dzcpu_pkg::ALU_ADC:
      begin
        wide   = {1'b0, operandA} + {1'b0, operandB} + carryIn;
        nibble = {1'b0, operandA[3:0]} + {1'b0, operandB[3:0]} + carryIn;
        newFlags[`DZCPU_FLAG_H] = nibble[4];
        newFlags[`DZCPU_FLAG_C] = wide[`DZCPU_DATA_W];
      end
      dzcpu_pkg::ALU_SUB:
      begin
        wide   = {1'b0, operandA} - {1'b0, operandB};
        nibble = {1'b0, operandA[3:0]} - {1'b0, operandB[3:0]};
        newFlags[`DZCPU_FLAG_N] = 1'b1;
        newFlags[`DZCPU_FLAG_H] = nibble[4];
        newFlags[`DZCPU_FLAG_C] = wide[`DZCPU_DATA_W];
      end
      dzcpu_pkg::ALU_AND:
      begin
        wide = {1'b0, operandA & operandB};
        newFlags[`DZCPU_FLAG_H] = 1'b1;   // AND always sets H
        newFlags[`DZCPU_FLAG_C] = 1'b0;
      end
      dzcpu_pkg::ALU_XOR:
      begin
        wide = {1'b0, operandA ^ operandB};
        newFlags[`DZCPU_FLAG_C] = 1'b0;
      end
      dzcpu_pkg::ALU_OR:
      begin
        wide = {1'b0, operandA | operandB};
        newFlags[`DZCPU_FLAG_C] = 1'b0;
      end
      dzcpu_pkg::ALU_INC:
      begin
        wide = {1'b0, operandA} + 1'b1;
        newFlags[`DZCPU_FLAG_H] = (wide[3:0] == 4'h0);
      end
      dzcpu_pkg::ALU_DEC:
      begin
        wide = {1'b0, operandA} - 1'b1;
        newFlags[`DZCPU_FLAG_N] = 1'b1;
        newFlags[`DZCPU_FLAG_H] = (wide[3:0] == 4'hF);
      end
    endcase
    newFlags[`DZCPU_FLAG_Z] = (wide[`DZCPU_DATA_W-1:0] == '0);
  end

endmodule

//--- dzcpuQueue.sv
`include "dzcpu_cfg.svh"

module dzcpuQueue
(
  input  logic                 iClock,
  input  logic                 rstN,
  input  logic                 push,
  input  dzcpu_pkg::queueItemT pushItem,
  input  logic                 pop,
  output dzcpu_pkg::queueItemT headItem,
  output logic                 empty,
  output logic                 almostFull
);

  localparam int PTR_W = $clog2(`DZCPU_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`DZCPU_QUEUE_DEPTH + 1);

  dzcpu_pkg::queueItemT mem [`DZCPU_QUEUE_DEPTH];
  logic [PTR_W-1:0]     wrPtr;
  logic [PTR_W-1:0]     rdPtr;
  logic [CNT_W-1:0]     count;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`DZCPU_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign headItem   = mem[rdPtr];   // Show-ahead
  assign empty      = (count == '0);
  assign almostFull = (count >= CNT_W'(`DZCPU_QUEUE_DEPTH - 1));  // Room for one in-flight item

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge iClock)
  begin
    if (push)
      mem[wrPtr] <= pushItem;
  end

endmodule

//--- dzcpuFetch.sv
`include "dzcpu_cfg.svh"

module dzcpuFetch
(
  input  logic                       iClock,
  input  logic                       rstN,
  input  logic [`DZCPU_DATA_W-1:0]   readData,
  input  logic                       storeValid,
  input  logic [`DZCPU_ADDR_W-1:0]   storeAddress,
  input  logic [`DZCPU_DATA_W-1:0]   storeData,
  input  logic                       almostFull,
  output logic [`DZCPU_ADDR_W-1:0]   address,
  output logic [`DZCPU_DATA_W-1:0]   writeData,
  output logic                       readRequest,
  output logic                       writeEnable,
  output logic                       push,
  output dzcpu_pkg::queueItemT       pushItem
);

  logic [`DZCPU_ADDR_W-1:0] pc;
  dzcpu_pkg::fetchStateE    state;
  logic                     running;        // Low in the first cycle after reset
  logic                     byteArriving;   // Read issued last cycle
  logic [`DZCPU_DATA_W-1:0] opcodeHold;
  logic                     needsImm;

  // Opcodes followed by an operand byte
  function automatic logic hasImmediate(input logic [`DZCPU_DATA_W-1:0] opcode);
    logic ldImm;
    logic aluImm;
    ldImm = (opcode[7:6] == 2'b00) && (opcode[2:0] == 3'b110);
    case (opcode)
      8'hC6, 8'hCE, 8'hD6, 8'hE6, 8'hEE, 8'hF6: aluImm = 1'b1;
      default: aluImm = 1'b0;
    endcase
    return ldImm | aluImm;
  endfunction

  // ----------------------------------------
  // Memory port where stores win over reads
  assign readRequest = running & ~storeValid & ~almostFull;
  assign writeEnable = storeValid;
  assign address     = storeValid ? storeAddress : pc;
  assign writeData   = storeData;

  // ----------------------------------------
  // Item assembly
  assign needsImm = hasImmediate(readData);
  assign push = byteArriving & ((state == dzcpu_pkg::FETCH_IMM) | ~needsImm);

  always_comb
  begin
    if (state == dzcpu_pkg::FETCH_IMM)
    begin
      pushItem.opcode = opcodeHold;
      pushItem.imm    = readData;
      pushItem.hasImm = 1'b1;
    end
    else
    begin
      pushItem.opcode = readData;
      pushItem.imm    = '0;
      pushItem.hasImm = 1'b0;
    end
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      running      <= 1'b0;
      byteArriving <= 1'b0;
      pc           <= `DZCPU_PC_RESET;
      state        <= dzcpu_pkg::FETCH_OPCODE;
    end
    else
    begin
      running      <= 1'b1;
      byteArriving <= readRequest;
      if (readRequest)
        pc <= pc + 1'b1;   // PC only counts up without jumps
      if (byteArriving)
      begin
        if (state == dzcpu_pkg::FETCH_IMM)
          state <= dzcpu_pkg::FETCH_OPCODE;
        else if (needsImm)
          state <= dzcpu_pkg::FETCH_IMM;
      end
    end
  end

  always_ff @(posedge iClock)
  begin
    if (byteArriving && state == dzcpu_pkg::FETCH_OPCODE)
      opcodeHold <= readData;
  end

endmodule

//--- dzcpuExec.sv
`include "dzcpu_cfg.svh"

module dzcpuExec
(
  input  logic                     iClock,
  input  logic                     rstN,
  input  dzcpu_pkg::queueItemT     headItem,
  input  logic                     empty,
  output logic                     pop,
  output logic                     storeValid,
  output logic [`DZCPU_ADDR_W-1:0] storeAddress,
  output logic [`DZCPU_DATA_W-1:0] storeData
);

  logic [`DZCPU_DATA_W-1:0] regFile [8];   // B C D E H L - A
  logic [`DZCPU_DATA_W-1:0] flagReg;
  logic [`DZCPU_ADDR_W-1:0] sp;
  dzcpu_pkg::execStateE     state;
  dzcpu_pkg::execStateE     phase;
  logic [`DZCPU_DATA_W-1:0] opcode;
  dzcpu_pkg::regIdxE        dstIdx;
  dzcpu_pkg::regIdxE        srcIdx;
  logic isLoad;
  logic isStore;
  logic isIncDec;
  logic isAlu;
  logic isPush;
  logic active;
  dzcpu_pkg::aluOpE         aluOp;
  logic                     aluOpValid;
  logic [`DZCPU_DATA_W-1:0] operandA;
  logic [`DZCPU_DATA_W-1:0] operandB;
  logic [`DZCPU_DATA_W-1:0] aluResult;
  logic [`DZCPU_DATA_W-1:0] aluFlags;
  logic [1:0]               pairSel;
  logic [`DZCPU_DATA_W-1:0] pairHigh;
  logic [`DZCPU_DATA_W-1:0] pairLow;

  // ----------------------------------------
  // Decode
  assign opcode = headItem.opcode;
  assign dstIdx = dzcpu_pkg::regIdxE'(opcode[5:3]);
  assign srcIdx = dzcpu_pkg::regIdxE'(opcode[2:0]);

  assign isLoad = (dstIdx != dzcpu_pkg::REG_M) &&
                  ((opcode[7:6] == 2'b00 && opcode[2:0] == 3'b110) ||
                   (opcode[7:6] == 2'b01 && srcIdx != dzcpu_pkg::REG_M));
  assign isStore  = (opcode[7:6] == 2'b01) && (dstIdx == dzcpu_pkg::REG_M) &&
                    (srcIdx != dzcpu_pkg::REG_M);
  assign isIncDec = (opcode[7:6] == 2'b00) && (opcode[2:1] == 2'b10) &&
                    (dstIdx != dzcpu_pkg::REG_M);
  assign isAlu    = aluOpValid &&
                    ((opcode[7:6] == 2'b10 && srcIdx != dzcpu_pkg::REG_M) ||
                     (opcode[7:6] == 2'b11 && opcode[2:0] == 3'b110));
  assign isPush   = (opcode[7:6] == 2'b11) && (opcode[3:0] == 4'h5);

  always_comb
  begin
    aluOpValid = 1'b1;
    case (opcode[5:3])
      3'd0: aluOp = dzcpu_pkg::ALU_ADD;
      3'd1: aluOp = dzcpu_pkg::ALU_ADC;
      3'd2: aluOp = dzcpu_pkg::ALU_SUB;
      3'd4: aluOp = dzcpu_pkg::ALU_AND;
      3'd5: aluOp = dzcpu_pkg::ALU_XOR;
      3'd6: aluOp = dzcpu_pkg::ALU_OR;
      default:
      begin
        aluOp      = dzcpu_pkg::ALU_ADD;
        aluOpValid = 1'b0;   // SBC and CP run as NOP
      end
    endcase
    if (isIncDec)
      aluOp = opcode[0] ? dzcpu_pkg::ALU_DEC : dzcpu_pkg::ALU_INC;
  end

  assign operandA = isIncDec ? regFile[dstIdx] : regFile[dzcpu_pkg::REG_A];
  assign operandB = headItem.hasImm ? headItem.imm : regFile[srcIdx];

  dzcpuAlu alu_i
  (
    .op       (aluOp),
    .operandA (operandA),
    .operandB (operandB),
    .flags    (flagReg),
    .result   (aluResult),
    .newFlags (aluFlags)
  );

  // ----------------------------------------
  // PUSH sequencing and stores
  always_comb
  begin
    phase = state;
    if (state == dzcpu_pkg::EXEC_IDLE && !empty && isPush)
      phase = dzcpu_pkg::EXEC_PUSH_HIGH;
  end

  assign active = !empty && (phase == dzcpu_pkg::EXEC_IDLE);
  assign pop    = !empty && (phase != dzcpu_pkg::EXEC_PUSH_HIGH);   // PUSH leaves on its 2nd cycle

  assign pairSel  = opcode[5:4];
  assign pairHigh = (pairSel == 2'b11) ? regFile[dzcpu_pkg::REG_A] : regFile[{pairSel, 1'b0}];
  assign pairLow  = (pairSel == 2'b11) ? flagReg : regFile[{pairSel, 1'b1}];

  always_comb
  begin
    storeValid   = 1'b0;
    storeAddress = {regFile[dzcpu_pkg::REG_H], regFile[dzcpu_pkg::REG_L]};
    storeData    = operandB;
    case (phase)
      dzcpu_pkg::EXEC_PUSH_HIGH:
      begin
        storeValid   = 1'b1;
        storeAddress = sp - 16'd1;
        storeData    = pairHigh;
      end
      dzcpu_pkg::EXEC_PUSH_LOW:
      begin
        storeValid   = 1'b1;
        storeAddress = sp - 16'd2;
        storeData    = pairLow;
      end
      default: storeValid = active & isStore;
    endcase
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 8; i++)
        regFile[i] <= '0;
      flagReg <= `DZCPU_FLAGS_RESET;
      sp      <= `DZCPU_SP_RESET;
      state   <= dzcpu_pkg::EXEC_IDLE;
    end
    else
    begin
      state <= (phase == dzcpu_pkg::EXEC_PUSH_HIGH) ? dzcpu_pkg::EXEC_PUSH_LOW
                                                     : dzcpu_pkg::EXEC_IDLE;
      if (phase == dzcpu_pkg::EXEC_PUSH_LOW)
        sp <= sp - 16'd2;
      if (active && isLoad)
        regFile[dstIdx] <= operandB;
      else if (active && isIncDec)
        regFile[dstIdx] <= aluResult;
      else if (active && isAlu)
        regFile[dzcpu_pkg::REG_A] <= aluResult;
      if (active && (isIncDec || isAlu))
        flagReg <= aluFlags;
    end
  end

endmodule

//--- dzcpuTop.sv
`include "dzcpu_cfg.svh"

module dzcpuTop
(
  input  logic                     iClock,
  input  logic                     rstN,
  input  logic [`DZCPU_DATA_W-1:0] readData,
  output logic [`DZCPU_DATA_W-1:0] writeData,
  output logic [`DZCPU_ADDR_W-1:0] address,
  output logic                     readRequest,
  output logic                     writeEnable
);

  logic                     storeValid;
  logic [`DZCPU_ADDR_W-1:0] storeAddress;
  logic [`DZCPU_DATA_W-1:0] storeData;
  logic                     push;
  logic                     pop;
  logic                     empty;
  logic                     almostFull;
  dzcpu_pkg::queueItemT     pushItem;
  dzcpu_pkg::queueItemT     headItem;

  dzcpuFetch fetch_i
  (
    .iClock       (iClock),
    .rstN         (rstN),
    .readData     (readData),
    .storeValid   (storeValid),
    .storeAddress (storeAddress),
    .storeData    (storeData),
    .almostFull   (almostFull),
    .address      (address),
    .writeData    (writeData),
    .readRequest  (readRequest),
    .writeEnable  (writeEnable),
    .push         (push),
    .pushItem     (pushItem)
  );

  dzcpuQueue queue_i
  (
    .iClock     (iClock),
    .rstN       (rstN),
    .push       (push),
    .pushItem   (pushItem),
    .pop        (pop),
    .headItem   (headItem),
    .empty      (empty),
    .almostFull (almostFull)
  );

  dzcpuExec exec_i
  (
    .iClock       (iClock),
    .rstN         (rstN),
    .headItem     (headItem),
    .empty        (empty),
    .pop          (pop),
    .storeValid   (storeValid),
    .storeAddress (storeAddress),
    .storeData    (storeData)
  );

endmodule

//--- tbClock.sv
module tbClock
(
  output logic iClock,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 10;

  initial
  begin
    iClock = 1'b0;
    forever #5 iClock = ~iClock;   // 10 ns period
  end

  initial
  begin
    rstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge iClock);
    #1 rstN = 1'b1;   // Released just after an edge
  end

endmodule

//--- dzcpu_sva.sv
`include "dzcpu_cfg.svh"

module dzcpuSva
(
  input logic                     iClock,
  input logic                     rstN,
  input logic                     readRequest,
  input logic                     writeEnable,
  input logic [`DZCPU_ADDR_W-1:0] address
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`DZCPU_ADDR_W-1:0] lastRead;
  logic                     haveRead;

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      haveRead <= 1'b0;
      lastRead <= '0;
    end
    else if (readRequest)
    begin
      haveRead <= 1'b1;
      lastRead <= address;
    end
  end

  noReadWrite: assert property (@(posedge iClock) !(readRequest && writeEnable))
    else $error("readRequest and writeEnable are high together");

  quietInReset: assert property (@(posedge iClock) !rstN |-> !(readRequest || writeEnable))
    else $error("memory port active while rstN is low");

  // PC only counts up
  readOrder: assert property (@(posedge iClock) disable iff (!rstN)
      (readRequest && haveRead) |-> (address == lastRead + 1'b1))
    else $error("read address did not follow the previous read");

endmodule

bind dzcpuTop dzcpuSva sva_i
(
  .iClock      (iClock),
  .rstN        (rstN),
  .readRequest (readRequest),
  .writeEnable (writeEnable),
  .address     (address)
);

//--- dzcpu_tb.sv
`include "dzcpu_cfg.svh"

module dzcpuTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_INSTR = 300;
  localparam int CODE_SIZE = 1024;
  localparam int NUM_TESTS = 6;
  localparam int T_RESET = 0;
  localparam int T_STORE = 1;
  localparam int T_ALU   = 2;
  localparam int T_FLAGS = 3;
  localparam int T_STACK = 4;
  localparam int T_BACK  = 5;
  // Kinds of expected writes
  localparam int W_STORE = 0;   // LD (HL),r
  localparam int W_PAIR  = 1;   // PUSH BC, DE or HL
  localparam int W_ACC   = 2;   // A from PUSH AF
  localparam int W_FLAGS = 3;   // F from PUSH AF

  logic        iClock;
  logic        rstN;
  logic [7:0]  readData;
  logic [7:0]  writeData;
  logic [15:0] address;
  logic        readRequest;
  logic        writeEnable;

  logic [7:0]  code [CODE_SIZE];
  int          progLen;
  logic [31:0] lfsrState;
  int          pushRun;
  int          longestBurst;

  // ISA model state
  logic [7:0]  mReg [8];
  logic [7:0]  mF;
  logic [15:0] mSp;

  int expAddr [$];
  int expData [$];
  int expKind [$];
  int gotAddr [$];
  int gotData [$];

  int    checkCount [NUM_TESTS];
  int    failCount [NUM_TESTS];
  string testNames [NUM_TESTS] = '{"resetFetch", "loadStore", "aluResult", "flags", "stack",
                                   "backPressure"};

  logic        pendingRead;
  logic [15:0] pendingAddr;
  int          readsSeen;
  int          lastReadAddr;

  tbClock clock_i
  (
    .iClock (iClock),
    .rstN   (rstN)
  );

  dzcpuTop dut_i
  (
    .iClock      (iClock),
    .rstN        (rstN),
    .readData    (readData),
    .writeData   (writeData),
    .address     (address),
    .readRequest (readRequest),
    .writeEnable (writeEnable)
  );

  // ----------------------------------------
  // Random program and reference model
  function automatic logic [7:0] randBits(input int n);
    logic [7:0] val;
    logic       fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      val = {val[6:0], fb};
    end
    return val;
  endfunction

  function automatic logic [2:0] pickReg();
    logic [2:0] r;
    r = randBits(3);
    return (r == 3'd6) ? 3'd7 : r;   // No (HL) slot
  endfunction

  function automatic logic [2:0] pickAluOp();
    logic [2:0] op;
    op = randBits(3);
    if (op == 3'd3)
      op = 3'd0;   // SBC not supported
    else if (op == 3'd7)
      op = 3'd6;   // Nor CP
    return op;
  endfunction

  function automatic void emit(input logic [7:0] b);
    code[progLen] = b;
    progLen++;
  endfunction

  function automatic void expectWrite(input logic [15:0] addr, input logic [7:0] data,
                                      input int kind);
    expAddr.push_back(addr);
    expData.push_back(data);
    expKind.push_back(kind);
  endfunction

  // op 0..6 is the opcode ALU field, 8 is INC and 9 is DEC
  function automatic logic [7:0] aluModel(input int op, input logic [7:0] a,
                                          input logic [7:0] b);
    int         sum;
    int         cin;
    logic [7:0] res;
    logic       n;
    logic       h;
    logic       c;
    cin = (op == 1) ? int'(mF[4]) : 0;
    n = 1'b0;
    h = 1'b0;
    c = mF[4];
    case (op)
      0, 1:
      begin
        sum = a + b + cin;
        res = sum[7:0];
        h = ((a & 15) + (b & 15) + cin) > 15;
        c = sum > 255;
      end
      2:
      begin
        res = a - b;
        n = 1'b1;
        h = a[3:0] < b[3:0];
        c = a < b;
      end
      4:
      begin
        res = a & b;
        h = 1'b1;
        c = 1'b0;
      end
      5:
      begin
        res = a ^ b;
        c = 1'b0;
      end
      6:
      begin
        res = a | b;
        c = 1'b0;
      end
      8:
      begin
        res = a + 8'd1;
        h = (res[3:0] == 4'h0);
      end
      default:
      begin
        res = a - 8'd1;
        n = 1'b1;
        h = (res[3:0] == 4'hF);
      end
    endcase
    mF = {res == 8'd0, n, h, c, 4'h0};
    return res;
  endfunction

  task automatic doPush(input logic [1:0] pair);
    logic [7:0] high;
    logic [7:0] low;
    emit({2'b11, pair, 4'h5});
    high = (pair == 2'd3) ? mReg[7] : mReg[{pair, 1'b0}];
    low  = (pair == 2'd3) ? mF : mReg[{pair, 1'b1}];
    expectWrite(mSp - 16'd1, high, (pair == 2'd3) ? W_ACC : W_PAIR);
    expectWrite(mSp - 16'd2, low, (pair == 2'd3) ? W_FLAGS : W_PAIR);
    mSp = mSp - 16'd2;
    pushRun++;
    if (pushRun > longestBurst)
      longestBurst = pushRun;
  endtask

  task automatic genInstr(input int remaining, output int count);
    int         sel;
    int         burst;
    logic [2:0] r;
    logic [2:0] s;
    logic [2:0] op;
    logic [7:0] n;
    count = 1;
    sel = randBits(4);
    if (sel < 12)
      pushRun = 0;
    case (sel)
      0: emit(8'h00);
      1, 2:
      begin
        r = pickReg();
        n = randBits(8);
        emit({2'b00, r, 3'b110});
        emit(n);
        mReg[r] = n;
      end
      3:
      begin
        r = pickReg();
        s = pickReg();
        emit({2'b01, r, s});
        mReg[r] = mReg[s];
      end
      4, 5:
      begin
        s = pickReg();
        emit({2'b01, 3'b110, s});
        expectWrite({mReg[4], mReg[5]}, mReg[s], W_STORE);
      end
      6, 7:
      begin
        r = pickReg();
        emit({2'b00, r, 2'b10, sel == 7});
        mReg[r] = aluModel((sel == 7) ? 9 : 8, mReg[r], 8'h00);
      end
      8, 9:
      begin
        op = pickAluOp();
        s = pickReg();
        emit({2'b10, op, s});
        mReg[7] = aluModel(op, mReg[7], mReg[s]);
      end
      10, 11:
      begin
        op = pickAluOp();
        n = randBits(8);
        emit({2'b11, op, 3'b110});
        emit(n);
        mReg[7] = aluModel(op, mReg[7], n);
      end
      12, 13: doPush(randBits(2));
      14:
      begin
        burst = 4 + randBits(2);   // Long enough to fill the queue
        if (burst > remaining)
          burst = remaining;
        for (int i = 0; i < burst; i++)
          doPush(randBits(2));
        count = burst;
      end
      default: doPush(2'd3);
    endcase
  endtask

  task automatic buildProgram();
    int made;
    int count;
    progLen = 0;
    pushRun = 0;
    longestBurst = 0;
    for (int i = 0; i < 8; i++)
      mReg[i] = 8'h00;
    mF  = `DZCPU_FLAGS_RESET;
    mSp = `DZCPU_SP_RESET;
    made = 0;
    while (made < NUM_INSTR)
    begin
      genInstr(NUM_INSTR - made, count);
      made += count;
    end
  endtask

  // ----------------------------------------
  // Checking
  task automatic checkValue(input string name, input int testIdx, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount[testIdx]++;
    if (actual !== expected)
    begin
      failCount[testIdx]++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic reportProblem(input int testIdx, input string msg);
    failCount[testIdx]++;
    $display("Error in %s: %s", testNames[testIdx], msg);
  endtask

  task automatic compareWrites(input int t);
    string tag;
    for (int i = 0; i < expAddr.size() && i < gotAddr.size(); i++)
    begin
      tag = $sformatf("%s write %0d", testNames[t], i);
      if ((t == T_STORE && expKind[i] == W_STORE) || t == T_BACK ||
          (t == T_STACK && expKind[i] != W_STORE))
        checkValue({tag, " address"}, t, expAddr[i], gotAddr[i]);
      if ((t == T_STORE && expKind[i] == W_STORE) || t == T_BACK ||
          (t == T_ALU && expKind[i] == W_ACC) || (t == T_FLAGS && expKind[i] == W_FLAGS) ||
          (t == T_STACK && expKind[i] == W_PAIR))
        checkValue({tag, " data"}, t, expData[i], gotData[i]);
    end
  endtask

  task automatic printTestLine(input int t);
    $display("Test %-12s %0d checks, %0d failures", testNames[t], checkCount[t], failCount[t]);
  endtask

  function automatic logic [7:0] memRead(input logic [15:0] addr);
    return (addr < progLen) ? code[addr] : 8'h00;   // NOP past the program
  endfunction

  // ----------------------------------------
  // Memory model
  always @(negedge iClock)
  begin
    pendingRead = readRequest;
    pendingAddr = address;
    if (!rstN)
      checkValue("resetFetch quiet in reset", T_RESET, 32'd0, {30'd0, readRequest, writeEnable});
    if (rstN && writeEnable)
    begin
      gotAddr.push_back(address);
      gotData.push_back(writeData);
    end
    if (rstN && readRequest)
    begin
      checkValue((readsSeen == 0) ? "resetFetch first read" : "resetFetch read order", T_RESET,
                 (readsSeen == 0) ? 32'd0 : lastReadAddr + 1, address);
      lastReadAddr = address;
      readsSeen++;
    end
  end

  always @(posedge iClock)
  begin
    #1;
    if (pendingRead)
      readData = memRead(pendingAddr);   // One cycle after the request
  end

  initial
  begin
    int cycles;
    int limit;
    int totalChecks;
    int totalFails;
    readData     = 8'h00;
    pendingRead  = 1'b0;
    pendingAddr  = '0;
    readsSeen    = 0;
    lastReadAddr = 0;
    lfsrState    = 32'h5f68e974;
    buildProgram();
    limit = 6 * progLen + 200;
    wait (rstN === 1'b1);
    cycles = 0;
    // Done once fetch is well past the last program byte
    while (lastReadAddr < progLen + 8 && cycles < limit)
    begin
      @(posedge iClock);
      cycles++;
    end
    if (cycles >= limit)
      reportProblem(T_BACK, $sformatf("run timed out after %0d cycles", cycles));
    if (readsSeen == 0)
      reportProblem(T_RESET, "no read was ever issued");
    printTestLine(T_RESET);
    for (int t = T_STORE; t <= T_STACK; t++)
    begin
      compareWrites(t);
      printTestLine(t);
    end
    checkValue("backPressure write count", T_BACK, expAddr.size(), gotAddr.size());
    if (longestBurst < 4)
      reportProblem(T_BACK, "program has no PUSH burst long enough to fill the queue");
    compareWrites(T_BACK);
    printTestLine(T_BACK);
    totalChecks = 0;
    totalFails = 0;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      totalChecks += checkCount[t];
      totalFails += failCount[t];
    end
    $display("Summary: %0d tests, %0d checks, %0d failures", NUM_TESTS, totalChecks, totalFails);
    if (totalFails == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
dzcpu_pkg.sv
dzcpuAlu.sv
dzcpuQueue.sv
dzcpuFetch.sv
dzcpuExec.sv
dzcpuTop.sv
tbClock.sv
dzcpu_sva.sv
dzcpu_tb.sv

//--- Bender.yml
package:
  name: dzcpu

export_include_dirs:
  - .

sources:
  - dzcpu_pkg.sv
  - dzcpuAlu.sv
  - dzcpuQueue.sv
  - dzcpuFetch.sv
  - dzcpuExec.sv
  - dzcpuTop.sv
  - target: test
    files:
      - tbClock.sv
      - dzcpu_sva.sv
      - dzcpu_tb.sv
